//--- io_bus_pkg.sv
//////////////////////////////////////////////////
// I/O port bus constants, port map, device enum
// and the lane/dword word union
//////////////////////////////////////////////////

package io_bus_pkg;

    localparam int IO_ADDR_W = 16;
    localparam int IO_DATA_W = 32;
    localparam int IO_LANES  = 4;
    localparam int LANE_W    = $clog2(IO_LANES);

    // Dword-aligned window bases
    localparam logic [IO_ADDR_W-1:0] PIC_M_BASE    = 16'h0020;
    localparam logic [IO_ADDR_W-1:0] PIT_BASE      = 16'h0040;
    localparam logic [IO_ADDR_W-1:0] RTC_BASE      = 16'h0070;
    localparam logic [IO_ADDR_W-1:0] PIC_S_BASE    = 16'h00A0;
    localparam logic [IO_ADDR_W-1:0] HDD_DATA_BASE = 16'h01F0;

    // Byte registers behind each window, upper lanes unmapped
    localparam int PIT_REGS = 4;
    localparam int PIC_REGS = 2;
    localparam int RTC_REGS = 2;

    localparam logic [7:0] UNMAPPED_BYTE = 8'hFF;

    typedef enum logic [2:0] {
        dev_none       = 3'd0,
        dev_pit        = 3'd1,
        dev_pic_master = 3'd2,
        dev_pic_slave  = 3'd3,
        dev_rtc        = 3'd4,
        dev_hdd_data   = 3'd5
    } io_dev_e;

    // Byte devices use the lane view, the disk data port the dword view
    typedef union packed {
        logic [IO_DATA_W-1:0]       dword;
        logic [IO_LANES-1:0][7:0]   lane;
    } io_word_t;

endpackage

//--- io_if.sv
//////////////////////////////////////////////////
// Request and beat interfaces of the I/O bus
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface io_req_if;
    import io_bus_pkg::*;

    logic                   valid;
    logic                   ready;
    io_dev_e                dev;
    logic [IO_LANES-1:0]    lane_mask;
    logic                   write;
    logic [IO_DATA_W-1:0]   wdata;

    modport source (output valid, dev, lane_mask, write, wdata, input ready);
    modport sink   (input valid, dev, lane_mask, write, wdata, output ready);
endinterface

interface io_beat_if;
    import io_bus_pkg::*;

    logic                   beat_valid;
    io_dev_e                dev;
    logic [LANE_W-1:0]      lane;
    logic                   write;
    io_word_t               wdata;
    io_word_t               rdata;
    logic                   last;
    logic                   is_dword;

    modport source  (output beat_valid, dev, lane, write, wdata, last, is_dword, input rdata);
    modport target  (input beat_valid, dev, lane, write, wdata, last, is_dword, output rdata);
    modport monitor (input beat_valid, dev, lane, write, wdata, rdata, last, is_dword);
endinterface

//--- io_port_decode.sv
//////////////////////////////////////////////////
// Bus command acceptance and port address decode
//////////////////////////////////////////////////

`timescale 1ns/1ps

module io_port_decode (
    input  logic                                clk_sys,
    input  logic                                arst_n,
    input  logic [io_bus_pkg::IO_ADDR_W-1:0]    io_address,
    input  logic [io_bus_pkg::IO_LANES-1:0]     io_byteenable,
    input  logic                                io_read,
    input  logic                                io_write,
    input  logic [io_bus_pkg::IO_DATA_W-1:0]    io_writedata,
    output logic                                io_waitrequest,
    io_req_if.source                            req
);
    import io_bus_pkg::*;

    logic                   valid_q;
    io_dev_e                dev_q;
    logic [IO_LANES-1:0]    lane_mask_q;
    logic                   write_q;
    logic [IO_DATA_W-1:0]   wdata_q;
    logic                   accept;

    // Window match on the dword part of the port address
    function automatic io_dev_e decode_dev(input logic [IO_ADDR_W-1:0] addr);
        case (addr[IO_ADDR_W-1:2])
            PIT_BASE[IO_ADDR_W-1:2]:      return dev_pit;
            PIC_M_BASE[IO_ADDR_W-1:2]:    return dev_pic_master;
            PIC_S_BASE[IO_ADDR_W-1:2]:    return dev_pic_slave;
            RTC_BASE[IO_ADDR_W-1:2]:      return dev_rtc;
            HDD_DATA_BASE[IO_ADDR_W-1:2]: return dev_hdd_data;
            default:                      return dev_none;
        endcase
    endfunction

    // Stall only while the held request still waits for execute
    assign io_waitrequest = valid_q & ~req.ready;

    assign accept = (io_read | io_write) & ~io_waitrequest;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            valid_q     <= 1'b0;
            dev_q       <= dev_none;
            lane_mask_q <= '0;
            write_q     <= 1'b0;
            wdata_q     <= '0;
        end else begin
            if (accept) begin
                valid_q     <= 1'b1;
                dev_q       <= decode_dev(io_address);
                lane_mask_q <= io_byteenable;
                write_q     <= io_write;
                wdata_q     <= io_writedata;
            end else if (req.ready) begin
                // Held request went to execute this cycle
                valid_q <= 1'b0;
            end
        end
    end

    assign req.valid     = valid_q;
    assign req.dev       = dev_q;
    assign req.lane_mask = lane_mask_q;
    assign req.write     = write_q;
    assign req.wdata     = wdata_q;

endmodule

//--- io_lane_exec.sv
//////////////////////////////////////////////////
// Lane stepper, splits requests into device beats
//////////////////////////////////////////////////

`timescale 1ns/1ps

module io_lane_exec (
    input  logic        clk_sys,
    input  logic        arst_n,
    io_req_if.sink      req,
    io_beat_if.source   beat
);
    import io_bus_pkg::*;

    logic                   busy_q;
    io_dev_e                dev_q;
    logic                   write_q;
    io_word_t               wdata_q;
    logic [IO_LANES-1:0]    pend_q;
    logic                   dword_q;

    logic [LANE_W-1:0]      lane_sel;
    logic [IO_LANES-1:0]    pend_rest;
    logic                   last;
    logic                   take;

    // Lowest pending lane goes out first
    always_comb begin
        lane_sel = '0;
        for (int i = IO_LANES - 1; i >= 0; i--) begin
            if (pend_q[i]) begin
                lane_sel = LANE_W'(i);
            end
        end
        pend_rest = pend_q;
        pend_rest[lane_sel] = 1'b0;
    end

    assign last      = dword_q | (pend_rest == '0);
    assign req.ready = ~busy_q | last;
    assign take      = req.valid & req.ready;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            busy_q  <= 1'b0;
            dev_q   <= dev_none;
            write_q <= 1'b0;
            wdata_q <= '0;
            pend_q  <= '0;
            dword_q <= 1'b0;
        end else begin
            if (take) begin
                busy_q  <= 1'b1;
                write_q <= req.write;
                wdata_q <= req.wdata;
                pend_q  <= req.lane_mask;
                // Disk port and an empty byteenable both take a single beat
                dword_q <= (req.dev == dev_hdd_data) || (req.lane_mask == '0);
                if (req.dev != dev_hdd_data && req.lane_mask == '0) begin
                    dev_q <= dev_none;
                end else begin
                    dev_q <= req.dev;
                end
            end else if (busy_q) begin
                if (last) begin
                    busy_q <= 1'b0;
                end
                pend_q <= pend_rest;
            end
        end
    end

    assign beat.beat_valid = busy_q;
    assign beat.dev        = dev_q;
    assign beat.lane       = lane_sel;
    assign beat.write      = write_q;
    assign beat.wdata      = wdata_q;
    assign beat.last       = last;
    assign beat.is_dword   = dword_q;

endmodule

//--- io_device_regs.sv
//////////////////////////////////////////////////
// Stand-in device registers: timer, interrupt
// controllers, clock bytes and disk data word
//////////////////////////////////////////////////

`timescale 1ns/1ps

module io_device_regs (
    input  logic        clk_sys,
    input  logic        arst_n,
    io_beat_if.target   beat
);
    import io_bus_pkg::*;

    logic [PIT_REGS-1:0][7:0]   pit_q;
    logic [PIC_REGS-1:0][7:0]   pic_m_q;
    logic [PIC_REGS-1:0][7:0]   pic_s_q;
    logic [RTC_REGS-1:0][7:0]   rtc_q;
    logic [IO_DATA_W-1:0]       hdd_q;
    io_word_t                   rd;

    function automatic logic mapped(input logic [LANE_W-1:0] lane, input int nregs);
        return int'(lane) < nregs;
    endfunction

    // Read data sits in the beat's own lane, other lanes zero
    always_comb begin
        rd = '0;
        if (beat.is_dword) begin
            rd.dword = (beat.dev == dev_hdd_data) ? hdd_q : {IO_LANES{UNMAPPED_BYTE}};
        end else begin
            rd.lane[beat.lane] = UNMAPPED_BYTE;
            case (beat.dev)
                dev_pit:
                    if (mapped(beat.lane, PIT_REGS)) rd.lane[beat.lane] = pit_q[beat.lane];
                dev_pic_master:
                    if (mapped(beat.lane, PIC_REGS)) rd.lane[beat.lane] = pic_m_q[beat.lane[0]];
                dev_pic_slave:
                    if (mapped(beat.lane, PIC_REGS)) rd.lane[beat.lane] = pic_s_q[beat.lane[0]];
                dev_rtc:
                    if (mapped(beat.lane, RTC_REGS)) rd.lane[beat.lane] = rtc_q[beat.lane[0]];
                default: ;
            endcase
        end
    end

    assign beat.rdata = rd;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            pit_q   <= '0;
            pic_m_q <= '0;
            pic_s_q <= '0;
            rtc_q   <= '0;
            hdd_q   <= '0;
        end else if (beat.beat_valid && beat.write) begin
            case (beat.dev)
                dev_pit:
                    if (mapped(beat.lane, PIT_REGS)) pit_q[beat.lane] <= beat.wdata.lane[beat.lane];
                dev_pic_master:
                    if (mapped(beat.lane, PIC_REGS)) pic_m_q[beat.lane[0]] <= beat.wdata.lane[beat.lane];
                dev_pic_slave:
                    if (mapped(beat.lane, PIC_REGS)) pic_s_q[beat.lane[0]] <= beat.wdata.lane[beat.lane];
                dev_rtc:
                    if (mapped(beat.lane, RTC_REGS)) rtc_q[beat.lane[0]] <= beat.wdata.lane[beat.lane];
                dev_hdd_data:
                    hdd_q <= beat.wdata.dword;
                default: ;
            endcase
        end
    end

endmodule

//--- io_read_merge.sv
//////////////////////////////////////////////////
// Read beat merge and readdatavalid generation
//////////////////////////////////////////////////

`timescale 1ns/1ps

module io_read_merge (
    input  logic                                clk_sys,
    input  logic                                arst_n,
    io_beat_if.monitor                          beat,
    output logic [io_bus_pkg::IO_DATA_W-1:0]    io_readdata,
    output logic                                io_readdatavalid
);
    import io_bus_pkg::*;

    io_word_t   acc_q;
    logic       busy_q;
    io_word_t   base;
    io_word_t   merged;
    logic       capture;

    assign capture = beat.beat_valid & ~beat.write;

    // First beat of a read starts from a cleared word
    always_comb begin
        base   = busy_q ? acc_q : '0;
        merged = base;
        if (beat.is_dword) begin
            // Empty byteenable arrives as a dword beat to no device
            merged.dword = (beat.dev == dev_hdd_data) ? beat.rdata.dword : '0;
        end else begin
            merged.lane[beat.lane] = beat.rdata.lane[beat.lane];
        end
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            acc_q            <= '0;
            busy_q           <= 1'b0;
            io_readdata      <= '0;
            io_readdatavalid <= 1'b0;
        end else begin
            io_readdatavalid <= 1'b0;
            if (capture) begin
                acc_q  <= merged;
                busy_q <= ~beat.last;
                if (beat.last) begin
                    io_readdata      <= merged.dword;
                    io_readdatavalid <= 1'b1;
                end
            end
        end
    end

endmodule

//--- io_bus_top.sv
//////////////////////////////////////////////////
// I/O port bus top level
//////////////////////////////////////////////////

`timescale 1ns/1ps

module io_bus_top (
    input  logic                                clk_sys,
    input  logic                                arst_n,
    input  logic [io_bus_pkg::IO_ADDR_W-1:0]    io_address,
    input  logic [io_bus_pkg::IO_LANES-1:0]     io_byteenable,
    input  logic                                io_read,
    input  logic                                io_write,
    input  logic [io_bus_pkg::IO_DATA_W-1:0]    io_writedata,
    output logic                                io_waitrequest,
    output logic [io_bus_pkg::IO_DATA_W-1:0]    io_readdata,
    output logic                                io_readdatavalid
);

    io_req_if   req_bus ();
    io_beat_if  beat_bus ();

    io_port_decode u_io_port_decode (
        .clk_sys        (clk_sys),
        .arst_n         (arst_n),
        .io_address     (io_address),
        .io_byteenable  (io_byteenable),
        .io_read        (io_read),
        .io_write       (io_write),
        .io_writedata   (io_writedata),
        .io_waitrequest (io_waitrequest),
        .req            (req_bus)
    );

    io_lane_exec u_io_lane_exec (
        .clk_sys (clk_sys),
        .arst_n  (arst_n),
        .req     (req_bus),
        .beat    (beat_bus)
    );

    io_device_regs u_io_device_regs (
        .clk_sys (clk_sys),
        .arst_n  (arst_n),
        .beat    (beat_bus)
    );

    io_read_merge u_io_read_merge (
        .clk_sys          (clk_sys),
        .arst_n           (arst_n),
        .beat             (beat_bus),
        .io_readdata      (io_readdata),
        .io_readdatavalid (io_readdatavalid)
    );

endmodule

//--- io_bus_checker.sv
//////////////////////////////////////////////////
// Read result checker for the I/O bus testbench
//////////////////////////////////////////////////

`timescale 1ns/1ps

module io_bus_checker (
    input  logic                                clk_sys,
    input  logic                                arst_n,
    input  logic                                io_waitrequest,
    input  logic                                io_readdatavalid,
    input  logic [io_bus_pkg::IO_DATA_W-1:0]    io_readdata,
    input  logic                                test_done,
    output int                                  error_count,
    output int                                  missing_count,
    output int                                  pending_count
);

    logic [31:0]    vec_mem [0:511];
    logic [31:0]    exp_mem [0:127];
    int             exp_total = 0;
    int             reads_seen = 0;
    int             errors = 0;

    // Expected words of the read commands, in command order
    initial begin
        logic [8:0] vptr;
        vptr = '0;
        $readmemh("io_bus_vectors.txt", vec_mem);
        while (vec_mem[vptr] != 32'd0 && vptr < 9'd505) begin
            if (vec_mem[vptr] == 32'd2 && exp_total < 128) begin
                exp_mem[exp_total[6:0]] = vec_mem[vptr + 9'd4];
                exp_total++;
            end
            vptr = vptr + 9'd5;
        end
    end

    // Registered outputs, sampled mid-cycle
    always @(negedge clk_sys) begin
        if (!arst_n) begin
            if (io_waitrequest || io_readdatavalid) begin
                $display("Bus outputs not idle during reset at %0t", $time);
                errors++;
            end
        end else if (io_readdatavalid) begin
            if (reads_seen >= exp_total) begin
                $display("Unexpected readdatavalid at %0t with data %08h", $time, io_readdata);
                errors++;
            end else if (io_readdata !== exp_mem[reads_seen[6:0]]) begin
                $display("Mismatch at %0t: read %0d returned %08h, expected %08h",
                         $time, reads_seen, io_readdata, exp_mem[reads_seen[6:0]]);
                errors++;
            end
            reads_seen++;
        end
    end

    always @(posedge test_done) begin
        if (pending_count != 0) begin
            $display("%0d read results never arrived", pending_count);
        end
    end

    assign pending_count = (reads_seen < exp_total) ? exp_total - reads_seen : 0;
    assign missing_count = test_done ? pending_count : 0;
    assign error_count   = errors;

endmodule

//--- tb_io_bus.sv
//////////////////////////////////////////////////
// Testbench top with clock, reset and vector-driven
// bus commands with random idle gaps
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_io_bus;
    import io_bus_pkg::*;

    localparam int ACCEPT_WAIT = 50;
    localparam int DRAIN_WAIT  = 200;

    logic                   clk_sys;
    logic                   arst_n;
    logic [IO_ADDR_W-1:0]   io_address;
    logic [IO_LANES-1:0]    io_byteenable;
    logic                   io_read;
    logic                   io_write;
    logic [IO_DATA_W-1:0]   io_writedata;
    logic                   io_waitrequest;
    logic [IO_DATA_W-1:0]   io_readdata;
    logic                   io_readdatavalid;
    logic                   test_done;
    logic                   timed_out;
    int                     error_count;
    int                     missing_count;
    int                     pending_count;
    logic [31:0]            vec_mem [0:511];

    io_bus_top u_io_bus_top (
        .clk_sys          (clk_sys),
        .arst_n           (arst_n),
        .io_address       (io_address),
        .io_byteenable    (io_byteenable),
        .io_read          (io_read),
        .io_write         (io_write),
        .io_writedata     (io_writedata),
        .io_waitrequest   (io_waitrequest),
        .io_readdata      (io_readdata),
        .io_readdatavalid (io_readdatavalid)
    );

    io_bus_checker u_io_bus_checker (
        .clk_sys          (clk_sys),
        .arst_n           (arst_n),
        .io_waitrequest   (io_waitrequest),
        .io_readdatavalid (io_readdatavalid),
        .io_readdata      (io_readdata),
        .test_done        (test_done),
        .error_count      (error_count),
        .missing_count    (missing_count),
        .pending_count    (pending_count)
    );

    initial clk_sys = 1'b0;
    always #2 clk_sys = ~clk_sys;

    task automatic drive_idle();
        io_address    = '0;
        io_byteenable = '0;
        io_read       = 1'b0;
        io_write      = 1'b0;
        io_writedata  = '0;
    endtask

    // Holds the command until the DUT drops waitrequest
    task automatic issue_command(input logic [31:0] op, input logic [31:0] addr,
                                 input logic [31:0] be, input logic [31:0] wdata);
        int waited;
        waited        = 0;
        io_address    = addr[IO_ADDR_W-1:0];
        io_byteenable = be[IO_LANES-1:0];
        io_read       = (op == 32'd2);
        io_write      = (op == 32'd1);
        io_writedata  = wdata;
        @(negedge clk_sys);
        while (io_waitrequest && waited < ACCEPT_WAIT) begin
            @(negedge clk_sys);
            waited++;
        end
        if (io_waitrequest) begin
            $display("Timeout: command to port %04h was never accepted", addr[15:0]);
            timed_out = 1'b1;
        end
        @(posedge clk_sys);
        #1;
        drive_idle();
    endtask

    initial begin
        logic [8:0] vptr;
        int         gap;
        int         waited;
        arst_n    = 1'b0;
        test_done = 1'b0;
        timed_out = 1'b0;
        drive_idle();
        void'($urandom(32'h22aa_203b));
        $readmemh("io_bus_vectors.txt", vec_mem);
        repeat (3) @(posedge clk_sys);
        #1;
        arst_n = 1'b1;

        // Five words per command until an op of zero
        vptr = '0;
        while (vec_mem[vptr] != 32'd0 && vptr < 9'd505 && !timed_out) begin
            issue_command(vec_mem[vptr], vec_mem[vptr + 9'd1], vec_mem[vptr + 9'd2],
                          vec_mem[vptr + 9'd3]);
            vptr = vptr + 9'd5;
            gap  = $urandom_range(3, 0);
            repeat (gap) begin
                @(posedge clk_sys);
                #1;
            end
        end

        waited = 0;
        while (pending_count != 0 && waited < DRAIN_WAIT && !timed_out) begin
            @(posedge clk_sys);
            waited++;
        end
        if (pending_count != 0 && !timed_out) begin
            $display("Timeout: read results still outstanding after the last command");
            timed_out = 1'b1;
        end
        // Quiet window for stray readdatavalid pulses
        repeat (8) @(posedge clk_sys);
        test_done = 1'b1;
        #1;
        $display("Errors: %0d, missing reads: %0d, timeouts: %0d",
                 error_count, missing_count, timed_out);
        if (error_count == 0 && missing_count == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- io_bus_vectors.txt
// op address byteenable writedata expected, all hex
// op 1 writes, op 2 reads, op 0 ends the list
2 0040 F 00000000 00000000
2 0020 F 00000000 FFFF0000
2 00A0 F 00000000 FFFF0000
2 0070 F 00000000 FFFF0000
2 01F0 F 00000000 00000000
1 0041 2 00005A00 00000000
1 0021 2 0000C300 00000000
1 00A0 1 00000011 00000000
1 0070 1 00000022 00000000
1 0071 2 00003300 00000000
2 0041 2 00000000 00005A00
2 0021 2 00000000 0000C300
2 00A0 1 00000000 00000011
2 0070 3 00000000 00003322
2 0040 F 00000000 00005A00
1 0040 F 44332211 00000000
2 0040 F 00000000 44332211
1 0040 5 00AA00BB 00000000
2 0040 F 00000000 44AA22BB
2 0040 C 00000000 44AA0000
1 0020 F DEADBEEF 00000000
2 0020 F 00000000 FFFFBEEF
1 0070 F 01234567 00000000
2 0070 F 00000000 FFFF4567
2 0300 F 00000000 FFFFFFFF
2 0081 6 00000000 00FFFF00
1 01F0 F CAFEF00D 00000000
2 01F0 F 00000000 CAFEF00D
1 0042 4 00770000 00000000
2 0042 4 00000000 00770000
1 01F0 F 12345678 00000000
2 01F0 F 00000000 12345678
1 00A1 2 00009900 00000000
2 00A0 3 00000000 00009911
2 0040 0 00000000 00000000
1 0043 8 EE000000 00000000
2 0040 F 00000000 EE7722BB
2 0021 3 00000000 0000BEEF
0 0000 0 00000000 00000000

//--- build.f
io_bus_pkg.sv
io_if.sv
io_port_decode.sv
io_lane_exec.sv
io_device_regs.sv
io_read_merge.sv
io_bus_top.sv
io_bus_checker.sv
tb_io_bus.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the I/O bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_io_bus -f build.f -o tb_io_bus
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/tb_io_bus)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
